// ==== Bender.yml ====
package:
  name: uart_bridge

export_include_dirs:
  - .

sources:
  - uart_bridge_pkg.sv
  - byte_fifo.sv
  - uart_tx.sv
  - uart_rx.sv
  - uart_reg_bank.sv
  - uart_bridge_top.sv
  - target: test
    files:
      - uart_bridge_tb.sv

// ==== bridge_settings.svh ====
/* Build-time constants of the UART register peripheral.
   Included by the package, the RTL modules and the testbench. */
`ifndef BRIDGE_SETTINGS_SVH
`define BRIDGE_SETTINGS_SVH

// Serial bit period in system clocks
`define BRIDGE_CLKS_PER_BIT 16

// Entries per byte FIFO, power of two
`define BRIDGE_FIFO_DEPTH 16

// Register map, byte addresses
`define BRIDGE_REG_CTRL   8'h00
`define BRIDGE_REG_STATUS 8'h04
`define BRIDGE_REG_TXDATA 8'h08
`define BRIDGE_REG_RXDATA 8'h0C
`define BRIDGE_REG_FIFO   8'h10

`endif

// ==== byte_fifo.sv ====
/* Synchronous byte FIFO with first-word-fall-through read data.
   Push and pop act at the clock edge; flush empties it in one cycle. */
`timescale 1ns/1ps
`default_nettype none
`include "bridge_settings.svh"

module byte_fifo import uart_bridge_pkg::*; #(
    parameter int DEPTH = `BRIDGE_FIFO_DEPTH
) (
    input  logic        clk,
    input  logic        rst,
    input  logic        flush,
    input  logic        push,
    input  logic        pop,
    input  byte_t       wdata,
    output byte_t       rdata,
    output fifo_count_t count,
    output logic        full,
    output logic        empty
);

    localparam int AW = $clog2(DEPTH);

    byte_t          mem [DEPTH];
    logic [AW-1:0]  wr_ptr;
    logic [AW-1:0]  rd_ptr;
    logic           do_push;
    logic           do_pop;

    assign full    = (count == fifo_count_t'(DEPTH));
    assign empty   = (count == '0);
    assign do_push = push && !full;   // Push on full is dropped
    assign do_pop  = pop && !empty;
    assign rdata   = mem[rd_ptr];     // Head of queue, valid when not empty

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= wdata;
        end
    end

    // Pointers wrap on their own since DEPTH is a power of two
    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_count_bound: assert property (@(posedge clk) disable iff (rst)
        count <= fifo_count_t'(DEPTH));

endmodule

`default_nettype wire

// ==== list.f ====
+incdir+.
uart_bridge_pkg.sv
byte_fifo.sv
uart_tx.sv
uart_rx.sv
uart_reg_bank.sv
uart_bridge_top.sv
uart_bridge_tb.sv

// ==== uart_bridge_pkg.sv ====
/* Shared types of the UART register peripheral: data widths,
   the host bus request, register layouts and state encodings. */
`default_nettype none
`include "bridge_settings.svh"

package uart_bridge_pkg;

    typedef logic [7:0]  byte_t;
    typedef logic [7:0]  reg_addr_t;
    typedef logic [31:0] reg_data_t;
    typedef logic [$clog2(`BRIDGE_FIFO_DEPTH + 1)-1:0] fifo_count_t;  // 0 to DEPTH

    // Host request, write and read are one-cycle strobes
    typedef struct packed {
        reg_addr_t addr;
        reg_data_t wdata;
        logic      write;
        logic      read;
    } reg_req_t;

    typedef struct packed {
        logic rsvd7;
        logic int_en_rx_rdy;
        logic int_en_tx_done;
        logic int_en_error;
        logic rsvd3;
        logic fifo_flush;  // Self-clearing
        logic rx_en;
        logic tx_en;
    } ctrl_reg_t;

    // Same order as STATUS bits 6:4
    typedef struct packed {
        logic rx_rdy;
        logic tx_done;
        logic error;
    } irq_flags_t;

    typedef struct packed {
        logic byte_done;
        logic frame_err;
        logic busy;
    } uart_event_t;

    typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;
    typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} rx_state_e;

endpackage

`default_nettype wire

// ==== uart_bridge_tb.sv ====
/* Testbench for the UART register peripheral. Runs a table of transmit,
   receive and bad-stop frames through the register bus and the serial lines,
   then covers overrun, FIFO flush and a disabled receiver. */
`timescale 1ns/1ps
`default_nettype none
`include "bridge_settings.svh"

module uart_bridge_tb import uart_bridge_pkg::*; ();

    localparam int BIT        = `BRIDGE_CLKS_PER_BIT;
    localparam int DEPTH      = `BRIDGE_FIFO_DEPTH;
    localparam int POLL_LIMIT = 400;   // Register reads, two cycles each

    // Flag values in {rx_rdy, tx_done, error} order
    localparam irq_flags_t RDY  = 3'b100;
    localparam irq_flags_t DONE = 3'b010;
    localparam irq_flags_t ERR  = 3'b001;

    typedef enum logic [1:0] {OP_TX, OP_RX, OP_RX_BAD} op_e;

    typedef struct packed {
        op_e        op;
        byte_t      data;    // Filled from $random before use
        irq_flags_t flags;   // Flags expected once the frame is done
    } step_t;

    logic        clk;
    logic        rst;
    reg_req_t    reg_req;
    reg_data_t   reg_rdata;
    logic        uart_txd;
    logic        uart_rxd;
    logic        irq;
    integer      seed = 18819;
    logic [31:0] rnd;
    step_t       steps [8];
    byte_t       rx_expect [$];   // Bytes the RX FIFO should hold, oldest first

    uart_bridge_top UUT (
        .clk(clk), .rst(rst), .reg_req(reg_req), .reg_rdata(reg_rdata),
        .uart_txd(uart_txd), .uart_rxd(uart_rxd), .irq(irq)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TB FAILED");
        $fatal(1, "Stopped at first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp) else
            fail_run($sformatf("Error at %0t: %s expected 0x%0h, got 0x%0h",
                               $time, name, exp, act));
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    task automatic reg_write(input reg_addr_t addr, input reg_data_t data);
        @(negedge clk);
        reg_req = '{addr: addr, wdata: data, write: 1'b1, read: 1'b0};
        @(negedge clk);
        reg_req.write = 1'b0;
    endtask

    task automatic reg_read(input reg_addr_t addr, output reg_data_t data);
        @(negedge clk);
        reg_req = '{addr: addr, wdata: '0, write: 1'b0, read: 1'b1};
        @(negedge clk);
        reg_req.read = 1'b0;
        data = reg_rdata;   // Registered at the edge of the strobe
    endtask

    task automatic read_check(input reg_addr_t addr, input string name,
                              input reg_data_t exp);
        reg_data_t val;
        reg_read(addr, val);
        check_value(name, exp, val);
    endtask

    task automatic poll_reg(input reg_addr_t addr, input reg_data_t mask,
                            input reg_data_t exp, input string what);
        reg_data_t val;
        int        tries;
        tries = 0;
        reg_read(addr, val);
        while ((val & mask) !== exp) begin
            tries++;
            if (tries > POLL_LIMIT) fail_run({"Timed out waiting for ", what});
            reg_read(addr, val);
        end
    endtask

    // One 8N1 frame on uart_rxd, then a bit period of idle line
    task automatic send_frame(input byte_t data, input logic stop_bit);
        logic [9:0] frame;
        frame = {stop_bit, data, 1'b0};
        for (int i = 0; i < 10; i++) begin
            @(negedge clk);
            uart_rxd = frame[i];
            wait_cycles(BIT - 1);
        end
        @(negedge clk);
        uart_rxd = 1'b1;
        wait_cycles(BIT);
    endtask

    task automatic capture_frame(output byte_t data);
        int waited;
        waited = 0;
        @(negedge clk);
        while (uart_txd !== 1'b0) begin
            waited++;
            if (waited > 4 * BIT) fail_run("Timed out waiting for a start bit on uart_txd");
            @(negedge clk);
        end
        wait_cycles(BIT / 2);   // Middle of the start bit
        check_value("uart_txd start bit", 0, uart_txd);
        for (int i = 0; i < 8; i++) begin
            wait_cycles(BIT);
            data[i] = uart_txd;
        end
        wait_cycles(BIT);
        check_value("uart_txd stop bit", 1, uart_txd);
    endtask

    task automatic drain_rx();
        while (rx_expect.size() > 0) begin
            read_check(`BRIDGE_REG_RXDATA, "RXDATA", {24'h0, rx_expect.pop_front()});
        end
    endtask

    initial begin
        byte_t got;
        reg_req  = '0;
        uart_rxd = 1'b1;
        rst      = 1'b1;
        steps[0] = '{OP_TX,     8'h00, DONE};
        steps[1] = '{OP_RX,     8'h00, RDY};
        steps[2] = '{OP_RX,     8'h00, RDY};
        steps[3] = '{OP_RX_BAD, 8'h00, ERR};
        steps[4] = '{OP_TX,     8'h00, DONE};
        steps[5] = '{OP_RX,     8'h00, RDY};
        steps[6] = '{OP_RX_BAD, 8'h00, ERR};
        steps[7] = '{OP_TX,     8'h00, DONE};
        wait_cycles(4);
        rst = 1'b0;

        check_value("irq", 0, irq);
        check_value("uart_txd", 1, uart_txd);
        read_check(`BRIDGE_REG_STATUS, "STATUS", 0);
        read_check(`BRIDGE_REG_FIFO, "FIFO", 0);

        reg_write(`BRIDGE_REG_CTRL, 32'h73);   // Both directions, all interrupts
        read_check(`BRIDGE_REG_CTRL, "CTRL", 32'h73);
        foreach (steps[i]) begin
            rnd = $random(seed);
            steps[i].data = rnd[7:0];
            case (steps[i].op)
                OP_TX: begin
                    reg_write(`BRIDGE_REG_TXDATA, {24'h0, steps[i].data});
                    capture_frame(got);
                    check_value("uart_txd data", {24'h0, steps[i].data}, {24'h0, got});
                end
                OP_RX: begin
                    send_frame(steps[i].data, 1'b1);
                    rx_expect.push_back(steps[i].data);
                end
                default: send_frame(steps[i].data, 1'b0);
            endcase
            poll_reg(`BRIDGE_REG_STATUS, 32'h70, {25'h0, steps[i].flags, 4'h0},
                     "the expected interrupt flag");
            check_value("irq", 1, irq);
            reg_write(`BRIDGE_REG_STATUS, {25'h0, steps[i].flags, 4'h0});
            read_check(`BRIDGE_REG_STATUS, "STATUS", (rx_expect.size() > 0) ? 32'h2 : 32'h0);
            check_value("irq", 0, irq);
        end
        read_check(`BRIDGE_REG_FIFO, "FIFO", rx_expect.size());
        drain_rx();
        read_check(`BRIDGE_REG_RXDATA, "RXDATA when empty", 0);
        read_check(`BRIDGE_REG_STATUS, "STATUS", 0);

        // Overrun with the transmitter held off so TX bytes stay queued
        reg_write(`BRIDGE_REG_CTRL, 32'h12);
        for (int i = 0; i < 3; i++) begin
            reg_write(`BRIDGE_REG_TXDATA, 32'h40 + i);
        end
        for (int i = 0; i <= DEPTH; i++) begin
            rnd = $random(seed);
            send_frame(rnd[7:0], 1'b1);
            if (i < DEPTH) rx_expect.push_back(rnd[7:0]);   // Last byte is lost
        end
        poll_reg(`BRIDGE_REG_STATUS, 32'h10, 32'h10, "the overrun error flag");
        check_value("irq", 1, irq);
        read_check(`BRIDGE_REG_FIFO, "FIFO", (32'd3 << 8) | DEPTH);
        drain_rx();
        rnd = $random(seed);
        send_frame(rnd[7:0], 1'b1);
        read_check(`BRIDGE_REG_FIFO, "FIFO before flush", 32'h0301);
        reg_write(`BRIDGE_REG_CTRL, 32'h16);
        read_check(`BRIDGE_REG_FIFO, "FIFO after flush", 0);
        read_check(`BRIDGE_REG_CTRL, "CTRL", 32'h12);   // Flush bit gone
        reg_write(`BRIDGE_REG_STATUS, 32'h70);
        read_check(`BRIDGE_REG_STATUS, "STATUS", 0);
        check_value("irq", 0, irq);

        // Receiver off, line activity must change nothing
        reg_write(`BRIDGE_REG_CTRL, 32'h70);
        rnd = $random(seed);
        send_frame(rnd[7:0], 1'b1);
        send_frame(~rnd[7:0], 1'b0);
        read_check(`BRIDGE_REG_FIFO, "FIFO", 0);
        read_check(`BRIDGE_REG_STATUS, "STATUS", 0);
        check_value("irq", 0, irq);

        $display("TB PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== uart_bridge_top.sv ====
/* Top level of the UART peripheral. Connects the register bank, the TX and
   RX byte FIFOs, the transmitter and the receiver. */
`timescale 1ns/1ps
`default_nettype none
`include "bridge_settings.svh"

module uart_bridge_top import uart_bridge_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  reg_req_t  reg_req,
    output reg_data_t reg_rdata,
    output logic      uart_txd,
    input  logic      uart_rxd,
    output logic      irq
);

    ctrl_reg_t   ctrl;
    logic        tx_push;
    byte_t       tx_wdata;
    logic        tx_pop;
    byte_t       tx_head;
    fifo_count_t tx_count;
    logic        tx_full;
    logic        tx_empty;
    logic        tx_busy;
    logic        tx_frame_done;
    logic        rx_push;
    logic        rx_pop;
    byte_t       rx_byte;    // Receiver shift register
    byte_t       rx_head;    // RX FIFO head
    fifo_count_t rx_count;
    logic        rx_full;
    uart_event_t rx_events;

    uart_reg_bank u_reg_bank (
        .clk(clk), .rst(rst),
        .reg_req(reg_req), .reg_rdata(reg_rdata),
        .ctrl(ctrl),
        .tx_push(tx_push), .tx_data(tx_wdata),
        .rx_pop(rx_pop), .rx_push(rx_push),
        .rx_data(rx_head), .rx_events(rx_events), .rx_full(rx_full),
        .tx_busy(tx_busy), .tx_frame_done(tx_frame_done), .tx_full(tx_full),
        .tx_count(tx_count), .rx_count(rx_count),
        .irq(irq)
    );

    byte_fifo #(.DEPTH(`BRIDGE_FIFO_DEPTH)) u_tx_fifo (
        .clk(clk), .rst(rst), .flush(ctrl.fifo_flush),
        .push(tx_push), .pop(tx_pop), .wdata(tx_wdata),
        .rdata(tx_head), .count(tx_count), .full(tx_full), .empty(tx_empty)
    );

    byte_fifo #(.DEPTH(`BRIDGE_FIFO_DEPTH)) u_rx_fifo (
        .clk(clk), .rst(rst), .flush(ctrl.fifo_flush),
        .push(rx_push), .pop(rx_pop), .wdata(rx_byte),
        .rdata(rx_head), .count(rx_count), .full(rx_full), .empty()
    );

    uart_tx u_uart_tx (
        .clk(clk), .rst(rst), .tx_en(ctrl.tx_en),
        .fifo_data(tx_head), .fifo_empty(tx_empty), .fifo_pop(tx_pop),
        .busy(tx_busy), .frame_done(tx_frame_done), .txd(uart_txd)
    );

    uart_rx u_uart_rx (
        .clk(clk), .rst(rst), .rx_en(ctrl.rx_en), .rxd(uart_rxd),
        .data(rx_byte), .events(rx_events)
    );

endmodule

`default_nettype wire

// ==== uart_reg_bank.sv ====
/* Register bank on the strobe bus: CTRL, STATUS, TXDATA, RXDATA and FIFO.
   Holds the sticky interrupt flags and drives the registered irq. */
`timescale 1ns/1ps
`default_nettype none
`include "bridge_settings.svh"

module uart_reg_bank import uart_bridge_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  reg_req_t    reg_req,
    output reg_data_t   reg_rdata,
    output ctrl_reg_t   ctrl,
    output logic        tx_push,
    output byte_t       tx_data,
    output logic        rx_pop,
    output logic        rx_push,
    input  byte_t       rx_data,
    input  uart_event_t rx_events,
    input  logic        rx_full,
    input  logic        tx_busy,
    input  logic        tx_frame_done,
    input  logic        tx_full,
    input  fifo_count_t tx_count,
    input  fifo_count_t rx_count,
    output logic        irq
);

    irq_flags_t flags;
    irq_flags_t flag_set;
    irq_flags_t flag_clr;
    irq_flags_t irq_en;
    reg_data_t  rdata_next;
    logic       rx_avail;
    logic       overrun;
    logic       ctrl_wr;
    logic       status_wr;

    assign rx_avail  = (rx_count != '0);
    assign ctrl_wr   = reg_req.write && (reg_req.addr == `BRIDGE_REG_CTRL);
    assign status_wr = reg_req.write && (reg_req.addr == `BRIDGE_REG_STATUS);

    assign tx_push = reg_req.write && (reg_req.addr == `BRIDGE_REG_TXDATA);
    assign tx_data = reg_req.wdata[7:0];
    assign rx_pop  = reg_req.read && (reg_req.addr == `BRIDGE_REG_RXDATA) && rx_avail;

    // Receiver strobes, a byte into a full FIFO is lost
    assign rx_push = rx_events.byte_done && !rx_full;
    assign overrun = rx_events.byte_done && rx_full;

    assign flag_set = '{rx_rdy: rx_push, tx_done: tx_frame_done,
                        error: rx_events.frame_err || overrun};
    assign flag_clr = status_wr ? irq_flags_t'(reg_req.wdata[6:4]) : '0;  // Write one to clear
    assign irq_en   = '{rx_rdy: ctrl.int_en_rx_rdy, tx_done: ctrl.int_en_tx_done,
                        error: ctrl.int_en_error};

    always_ff @(posedge clk) begin
        if (rst) begin
            ctrl  <= '0;
            flags <= '0;
            irq   <= 1'b0;
        end else begin
            if (ctrl_wr) begin
                ctrl <= ctrl_reg_t'(reg_req.wdata[7:0] & 8'h77);  // Bits 3 and 7 stay zero
            end else begin
                ctrl.fifo_flush <= 1'b0;
            end
            flags <= (flags & ~flag_clr) | flag_set;   // New event beats a clear
            irq   <= |(flags & irq_en);
        end
    end

    always_comb begin
        case (reg_req.addr)
            `BRIDGE_REG_CTRL:   rdata_next = {24'b0, ctrl};
            `BRIDGE_REG_STATUS: rdata_next = {25'b0, flags, 1'b0, tx_full, rx_avail, tx_busy};
            `BRIDGE_REG_RXDATA: rdata_next = {24'b0, rx_avail ? rx_data : 8'h00};
            `BRIDGE_REG_FIFO:   rdata_next = {19'b0, tx_count, 3'b0, rx_count};
            default:            rdata_next = '0;
        endcase
    end

    // Read data holds until the next read strobe
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_rdata <= '0;
        end else if (reg_req.read) begin
            reg_rdata <= rdata_next;
        end
    end

    // Receiver reports a byte only after it has gone back to idle
    a_done_idle: assert property (@(posedge clk) disable iff (rst)
        rx_events.byte_done |-> !rx_events.busy);

endmodule

`default_nettype wire

// ==== uart_rx.sv ====
/* 8N1 deserializer. Finds the start edge on a synchronized line,
   samples mid-bit and reports each byte or framing error as a strobe. */
`timescale 1ns/1ps
`default_nettype none
`include "bridge_settings.svh"

module uart_rx import uart_bridge_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        rx_en,
    input  logic        rxd,
    output byte_t       data,
    output uart_event_t events
);

    localparam int CNT_W = $clog2(`BRIDGE_CLKS_PER_BIT);

    logic [1:0]       sync;      // Two-flop synchronizer
    logic             rxd_s;
    logic             rxd_d;     // Previous synchronized level, for edge detect
    rx_state_e        state;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    byte_t            shreg;
    logic             sample;
    logic             done_q;
    logic             err_q;

    assign rxd_s = sync[1];

    // Half a bit in START, full bit periods afterwards
    assign sample = (state == RX_START) ? (bit_cnt == CNT_W'(`BRIDGE_CLKS_PER_BIT / 2 - 1))
                                        : (bit_cnt == CNT_W'(`BRIDGE_CLKS_PER_BIT - 1));

    always_ff @(posedge clk) begin
        if (rst) begin
            sync  <= 2'b11;   // Line idles high
            rxd_d <= 1'b1;
        end else begin
            sync  <= {sync[0], rxd};
            rxd_d <= rxd_s;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= RX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            done_q  <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            done_q  <= 1'b0;
            err_q   <= 1'b0;
            bit_cnt <= (state == RX_IDLE || sample) ? '0 : bit_cnt + 1'b1;
            case (state)
                RX_IDLE: if (rx_en && rxd_d && !rxd_s) state <= RX_START;
                RX_START: if (sample) begin
                    state   <= rxd_s ? RX_IDLE : RX_DATA;   // Glitch returns to idle
                    bit_idx <= '0;
                end
                RX_DATA: if (sample) begin
                    bit_idx <= bit_idx + 1'b1;
                    if (bit_idx == 3'd7) state <= RX_STOP;
                end
                RX_STOP: if (sample) begin
                    state  <= RX_IDLE;
                    done_q <= rxd_s;
                    err_q  <= !rxd_s;   // Low stop bit
                end
                default: state <= RX_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RX_DATA && sample) begin
            shreg <= {rxd_s, shreg[7:1]};   // LSB arrives first
        end
    end

    assign data   = shreg;
    assign events = '{byte_done: done_q, frame_err: err_q, busy: (state != RX_IDLE)};

    a_one_outcome: assert property (@(posedge clk) disable iff (rst)
        (done_q || err_q) |-> !(done_q && err_q) && $past(state == RX_STOP));

endmodule

`default_nettype wire

// ==== uart_tx.sv ====
/* 8N1 serializer. Pulls a byte from the TX FIFO whenever idle and
   enabled, sends it LSB first and pulses frame_done after the stop bit. */
`timescale 1ns/1ps
`default_nettype none
`include "bridge_settings.svh"

module uart_tx import uart_bridge_pkg::*; (
    input  logic  clk,
    input  logic  rst,
    input  logic  tx_en,
    input  byte_t fifo_data,
    input  logic  fifo_empty,
    output logic  fifo_pop,
    output logic  busy,
    output logic  frame_done,
    output logic  txd
);

    localparam int CNT_W = $clog2(`BRIDGE_CLKS_PER_BIT);

    tx_state_e        state;
    logic [CNT_W-1:0] bit_cnt;   // Clocks into the current bit
    logic [2:0]       bit_idx;
    byte_t            shreg;
    logic             bit_end;

    assign bit_end    = (bit_cnt == CNT_W'(`BRIDGE_CLKS_PER_BIT - 1));
    assign fifo_pop   = (state == TX_IDLE) && tx_en && !fifo_empty;
    assign busy       = (state != TX_IDLE);
    assign frame_done = (state == TX_STOP) && bit_end;

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            shreg <= fifo_data;
        end else if (bit_end && (state == TX_START || state == TX_DATA)) begin
            shreg <= shreg >> 1;   // Next bit moves to shreg[0]
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state   <= TX_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
            txd     <= 1'b1;
        end else begin
            bit_cnt <= (state == TX_IDLE || bit_end) ? '0 : bit_cnt + 1'b1;
            case (state)
                TX_IDLE: if (fifo_pop) begin
                    state <= TX_START;
                    txd   <= 1'b0;   // Start bit
                end
                TX_START: if (bit_end) begin
                    state   <= TX_DATA;
                    bit_idx <= '0;
                    txd     <= shreg[0];
                end
                TX_DATA: if (bit_end) begin
                    if (bit_idx == 3'd7) begin
                        state <= TX_STOP;
                        txd   <= 1'b1;
                    end else begin
                        bit_idx <= bit_idx + 1'b1;
                        txd     <= shreg[0];
                    end
                end
                TX_STOP: if (bit_end) state <= TX_IDLE;
                default: state <= TX_IDLE;
            endcase
        end
    end

    // A pop starts the start bit at the very next edge
    a_pop_idle: assert property (@(posedge clk) disable iff (rst)
        fifo_pop |=> (busy && !txd));

endmodule

`default_nettype wire
